//--- src/rp_pkg.sv
`default_nettype none

package rp_pkg;

  //////////////////////////////////////////////////
  // samples
  //////////////////////////////////////////////////

  // converter resolution
  localparam int unsigned ADC_W = 14;

  // raw pin word, offset binary with negative slope
  typedef logic [ADC_W-1:0] adc_raw_t;
  // two's complement sample
  typedef logic signed [ADC_W-1:0] smp_t;

  //////////////////////////////////////////////////
  // calibration
  //////////////////////////////////////////////////

  // gain width, 8192 is unity
  localparam int unsigned CAL_MUL_W = 16;
  typedef logic signed [CAL_MUL_W-1:0] cal_mul_t;
  // offset, same scale as the sample
  typedef logic signed [ADC_W-1:0] cal_sum_t;

  // product back to sample scale
  localparam int unsigned CAL_SHIFT = 13;
  // product plus one bit of headroom for the offset add
  localparam int unsigned CAL_ACC_W = ADC_W + CAL_MUL_W + 1;

  // saturation bounds
  localparam smp_t SMP_MAX = smp_t'(8191);
  localparam smp_t SMP_MIN = smp_t'(-8192);

  //////////////////////////////////////////////////
  // acquisition
  //////////////////////////////////////////////////

  localparam int unsigned TS_W = 32;
  typedef logic [TS_W-1:0] ts_t;

  localparam int unsigned LEN_W = 16;
  typedef logic [LEN_W-1:0] len_t;

  // trigger pin hold-off after an accepted change
  localparam int unsigned DEB_CYCLES = 8;
  localparam int unsigned DEB_W = $clog2(DEB_CYCLES + 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ARMED,
    ST_CAPTURE
  } acq_state_t;

endpackage

`default_nettype wire

//--- src/acq_tmr_if.sv
`default_nettype none

interface acq_tmr_if import rp_pkg::*; ();

  // restart pulse, one cycle on trigger acceptance
  logic load;
  // post-trigger length, taken by the timer at load
  len_t len;
  // remaining count is one
  logic last;
  // free-running stamp
  ts_t  ts_now;
  // stamp latched at load
  ts_t  ts_trg;

  // state machine side
  modport fsm (
    output load,
    output len,
    input  last,
    input  ts_now,
    input  ts_trg
  );

  // timer side
  modport tmr (
    input  load,
    input  len,
    output last,
    output ts_now,
    output ts_trg
  );

endinterface

`default_nettype wire

//--- src/linear_cal.sv
`default_nettype none

module linear_cal import rp_pkg::*; (
  input  wire logic     adc_clk,
  input  wire logic     top_rst,
  // sample in
  input  wire smp_t     smp_i,
  // gain and offset
  input  wire cal_mul_t mul_i,
  input  wire cal_sum_t sum_i,
  // calibrated sample, one cycle later
  output smp_t          smp_o
);

  // full precision product
  logic signed [ADC_W+CAL_MUL_W-1:0] prod;
  // scaled product plus offset, before clipping
  logic signed [CAL_ACC_W-1:0]       acc;

  //////////////////////////////////////////////////
  // gain and offset
  //////////////////////////////////////////////////

  always_comb begin
    prod = smp_i * mul_i;
    // arithmetic shift keeps the sign of the product
    acc  = (prod >>> CAL_SHIFT) + sum_i;
  end

  //////////////////////////////////////////////////
  // saturation into the output register
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      smp_o <= '0;
    end else if (acc > SMP_MAX) begin
      // clip high
      smp_o <= SMP_MAX;
    end else if (acc < SMP_MIN) begin
      // clip low
      smp_o <= SMP_MIN;
    end else begin
      smp_o <= smp_t'(acc);
    end
  end

  // clipped result keeps the sign of the unclipped sum, no wrap
  a_smp_range: assert property (
    @(posedge adc_clk) disable iff (top_rst)
    !$past(top_rst) |-> (smp_o[ADC_W-1] == $past(acc[CAL_ACC_W-1]))
  );

endmodule

`default_nettype wire

//--- src/adc_frontend.sv
`default_nettype none

module adc_frontend import rp_pkg::*; (
  input  wire logic     adc_clk,
  input  wire logic     top_rst,
  // converter pins
  input  wire adc_raw_t adc_dat_i,
  // digital loopback
  input  wire logic     loop_en_i,
  input  wire smp_t     loop_smp_i,
  // calibration
  input  wire cal_mul_t mul_i,
  input  wire cal_sum_t sum_i,
  // calibrated sample
  output smp_t          smp_o
);

  // pin register output, already signed
  smp_t adc_smp;
  // calibration input after the loopback mux
  smp_t mux_smp;

  // input block register
  // msb kept, lower bits inverted for the negative slope
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      adc_smp <= '0;
    end else begin
      adc_smp <= {adc_dat_i[ADC_W-1], ~adc_dat_i[ADC_W-2:0]};
    end
  end

  // loopback replaces the converter with the calibrated dac stream
  assign mux_smp = loop_en_i ? loop_smp_i : adc_smp;

  linear_cal i_linear_cal (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .smp_i   (mux_smp),
    .mul_i   (mul_i),
    .sum_i   (sum_i),
    .smp_o   (smp_o)
  );

endmodule

`default_nettype wire

//--- src/dac_backend.sv
`default_nettype none

module dac_backend import rp_pkg::*; (
  input  wire logic     adc_clk,
  input  wire logic     top_rst,
  // generator sample
  input  wire smp_t     gen_i,
  // calibration
  input  wire cal_mul_t mul_i,
  input  wire cal_sum_t sum_i,
  // calibrated sample, also feeds the loopback
  output smp_t          cal_o,
  // converter word
  output adc_raw_t      dac_dat_o
);

  linear_cal i_linear_cal (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .smp_i   (gen_i),
    .mul_i   (mul_i),
    .sum_i   (sum_i),
    .smp_o   (cal_o)
  );

  // output register, signed to offset binary
  // converter has a negative slope, so lower bits flip too
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dac_dat_o <= '0;
    end else begin
      dac_dat_o <= {cal_o[ADC_W-1], ~cal_o[ADC_W-2:0]};
    end
  end

endmodule

`default_nettype wire

//--- src/edge_debounce.sv
`default_nettype none

module edge_debounce import rp_pkg::*; (
  input  wire logic adc_clk,
  input  wire logic top_rst,
  // asynchronous trigger pin
  input  wire logic pin_i,
  // one cycle per accepted rise
  output logic      edge_o
);

  // synchronizer stages
  logic             sync0;
  logic             sync1;
  // debounced level and its previous value
  logic             lvl;
  logic             lvl_d;
  // hold-off countdown
  logic [DEB_W-1:0] hold;
  // change taken into the level
  logic             accept;

  // only a settled counter lets a new level through
  assign accept = (hold == '0) && (sync1 != lvl);

  //////////////////////////////////////////////////
  // sync, level and hold-off
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      sync0 <= 1'b0;
      sync1 <= 1'b0;
      lvl   <= 1'b0;
      lvl_d <= 1'b0;
      hold  <= '0;
    end else begin
      sync0 <= pin_i;
      sync1 <= sync0;
      lvl_d <= lvl;
      if (accept) begin
        lvl  <= sync1;
        // bounces inside this window are dropped
        hold <= DEB_W'(DEB_CYCLES);
      end else if (hold != '0) begin
        hold <= hold - 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // rising edge of the clean level
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      edge_o <= 1'b0;
    end else begin
      edge_o <= lvl & ~lvl_d;
    end
  end

  // each pulse sits at the start of a running hold-off
  a_edge_single: assert property (
    @(posedge adc_clk) disable iff (top_rst)
    edge_o |-> (hold == DEB_W'(DEB_CYCLES - 1))
  );

endmodule

`default_nettype wire

//--- src/acq_timer.sv
`default_nettype none

module acq_timer import rp_pkg::*; (
  input  wire logic adc_clk,
  input  wire logic top_rst,
  // link to the acquisition FSM
  acq_tmr_if.tmr    tmr
);

  // samples still to capture, including the current one
  len_t cnt;

  //////////////////////////////////////////////////
  // time stamp
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      tmr.ts_now <= '0;
      tmr.ts_trg <= '0;
    end else begin
      // free running, wraps
      tmr.ts_now <= tmr.ts_now + 1'b1;
      // stamp of the cycle that accepted the trigger
      if (tmr.load) begin
        tmr.ts_trg <= tmr.ts_now;
      end
    end
  end

  //////////////////////////////////////////////////
  // post-trigger counter
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      cnt <= '0;
    end else if (tmr.load) begin
      // restart at the configured length
      cnt <= tmr.len;
    end else if (cnt != '0) begin
      // one sample consumed per cycle, stops at zero
      cnt <= cnt - 1'b1;
    end
  end

  // final sample of the capture
  assign tmr.last = (cnt == len_t'(1));

endmodule

`default_nettype wire

//--- src/acq_fsm.sv
`default_nettype none

module acq_fsm import rp_pkg::*; (
  input  wire logic adc_clk,
  input  wire logic top_rst,
  // control
  input  wire logic arm_i,
  input  wire logic sw_trg_i,
  input  wire logic ext_edge_i,
  input  wire len_t post_len_i,
  // calibrated sample stream
  input  wire smp_t smp_i,
  // timer link
  acq_tmr_if.fsm    tmr,
  // captured stream and status
  output smp_t      acq_dat_o,
  output logic      acq_vld_o,
  output logic      acq_done_o,
  output logic      acq_busy_o,
  output logic      trg_out_o,
  output ts_t       acq_ts_o
);

  acq_state_t state;
  acq_state_t state_nxt;
  // trigger taken this cycle
  logic       trg_acc;

  // triggers count only while armed
  assign trg_acc = (state == ST_ARMED) && (sw_trg_i || ext_edge_i);

  // timer restarts on acceptance with the current length
  assign tmr.load = trg_acc;
  assign tmr.len  = post_len_i;

  //////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    unique case (state)
      ST_IDLE:    if (arm_i) state_nxt = ST_ARMED;
      ST_ARMED:   if (trg_acc) state_nxt = ST_CAPTURE;
      // leave after the final sample
      ST_CAPTURE: if (tmr.last) state_nxt = ST_IDLE;
      default:    state_nxt = ST_IDLE;
    endcase
  end

  //////////////////////////////////////////////////
  // state and registered outputs
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      state      <= ST_IDLE;
      acq_vld_o  <= 1'b0;
      acq_busy_o <= 1'b0;
      trg_out_o  <= 1'b0;
      acq_dat_o  <= '0;
    end else begin
      state      <= state_nxt;
      // valid follows the capture state exactly
      acq_vld_o  <= (state_nxt == ST_CAPTURE);
      acq_busy_o <= (state_nxt != ST_IDLE);
      trg_out_o  <= trg_acc;
      // first sample is the one present at acceptance
      if (state_nxt == ST_CAPTURE) begin
        acq_dat_o <= smp_i;
      end
    end
  end

  // done marks the last valid sample
  assign acq_done_o = acq_vld_o & tmr.last;
  assign acq_ts_o   = tmr.ts_trg;

  // zero length would never raise last
  a_len_nonzero: assert property (
    @(posedge adc_clk) disable iff (top_rst)
    tmr.load |-> (post_len_i != '0)
  );

  // a frame opens one stamp after the accepted trigger
  a_vld_stamp: assert property (
    @(posedge adc_clk) disable iff (top_rst)
    $rose(acq_vld_o) |-> (tmr.ts_trg == tmr.ts_now - 1'b1)
  );

endmodule

`default_nettype wire

//--- src/rp_analog_top.sv
`default_nettype none

module rp_analog_top import rp_pkg::*; (
  input  wire logic     adc_clk,
  input  wire logic     top_rst,
  // converter input and generator sample
  input  wire adc_raw_t adc_dat_i,
  input  wire smp_t     dac_gen_i,
  input  wire logic     loop_en_i,
  // calibration
  input  wire cal_mul_t adc_cal_mul_i,
  input  wire cal_mul_t dac_cal_mul_i,
  input  wire cal_sum_t adc_cal_sum_i,
  input  wire cal_sum_t dac_cal_sum_i,
  // acquisition control
  input  wire logic     ext_trg_i,
  input  wire logic     sw_trg_i,
  input  wire logic     arm_i,
  input  wire len_t     post_len_i,
  // converter output
  output adc_raw_t      dac_dat_o,
  // captured stream and status
  output smp_t          acq_dat_o,
  output logic          acq_vld_o,
  output logic          acq_done_o,
  output logic          acq_busy_o,
  output logic          trg_out_o,
  output ts_t           acq_ts_o
);

  // calibrated samples
  smp_t adc_smp;
  smp_t dac_smp;
  // debounced external trigger
  logic ext_edge;

  acq_tmr_if i_tmr_if ();

  //////////////////////////////////////////////////
  // analog datapath
  //////////////////////////////////////////////////

  dac_backend i_dac_backend (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .gen_i     (dac_gen_i),
    .mul_i     (dac_cal_mul_i),
    .sum_i     (dac_cal_sum_i),
    .cal_o     (dac_smp),
    .dac_dat_o (dac_dat_o)
  );

  // calibrated dac sample doubles as the loopback source
  adc_frontend i_adc_frontend (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .adc_dat_i  (adc_dat_i),
    .loop_en_i  (loop_en_i),
    .loop_smp_i (dac_smp),
    .mul_i      (adc_cal_mul_i),
    .sum_i      (adc_cal_sum_i),
    .smp_o      (adc_smp)
  );

  //////////////////////////////////////////////////
  // acquisition
  //////////////////////////////////////////////////

  edge_debounce i_edge_debounce (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .pin_i   (ext_trg_i),
    .edge_o  (ext_edge)
  );

  acq_timer i_acq_timer (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .tmr     (i_tmr_if.tmr)
  );

  acq_fsm i_acq_fsm (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .arm_i      (arm_i),
    .sw_trg_i   (sw_trg_i),
    .ext_edge_i (ext_edge),
    .post_len_i (post_len_i),
    .smp_i      (adc_smp),
    .tmr        (i_tmr_if.fsm),
    .acq_dat_o  (acq_dat_o),
    .acq_vld_o  (acq_vld_o),
    .acq_done_o (acq_done_o),
    .acq_busy_o (acq_busy_o),
    .trg_out_o  (trg_out_o),
    .acq_ts_o   (acq_ts_o)
  );

endmodule

`default_nettype wire

//--- bench/tb_rp_analog.sv
`default_nettype none

module tb_rp_analog import rp_pkg::*; ();

  // one stimulus row with its expected results
  typedef struct packed {
    adc_raw_t adc_dat;
    smp_t     dac_gen;
    cal_mul_t adc_mul;
    cal_sum_t adc_sum;
    cal_mul_t dac_mul;
    cal_sum_t dac_sum;
    logic     loop_en;
    len_t     post_len;
    int       exp_acq;
    int       exp_dac;
  } row_t;

  logic     adc_clk;
  logic     top_rst;
  adc_raw_t adc_dat_i;
  smp_t     dac_gen_i;
  logic     loop_en_i;
  cal_mul_t adc_cal_mul_i;
  cal_mul_t dac_cal_mul_i;
  cal_sum_t adc_cal_sum_i;
  cal_sum_t dac_cal_sum_i;
  logic     ext_trg_i;
  logic     sw_trg_i;
  logic     arm_i;
  len_t     post_len_i;
  adc_raw_t dac_dat_o;
  smp_t     acq_dat_o;
  logic     acq_vld_o;
  logic     acq_done_o;
  logic     acq_busy_o;
  logic     trg_out_o;
  ts_t      acq_ts_o;

  row_t        rows[$];
  logic        rows_ready = 1'b0;
  logic [31:0] seed = 32'h9dc7;
  int          cyc = 0;
  int          errors = 0;

  rp_analog_top i_rp_analog_top (
    .adc_clk       (adc_clk),
    .top_rst       (top_rst),
    .adc_dat_i     (adc_dat_i),
    .dac_gen_i     (dac_gen_i),
    .loop_en_i     (loop_en_i),
    .adc_cal_mul_i (adc_cal_mul_i),
    .dac_cal_mul_i (dac_cal_mul_i),
    .adc_cal_sum_i (adc_cal_sum_i),
    .dac_cal_sum_i (dac_cal_sum_i),
    .ext_trg_i     (ext_trg_i),
    .sw_trg_i      (sw_trg_i),
    .arm_i         (arm_i),
    .post_len_i    (post_len_i),
    .dac_dat_o     (dac_dat_o),
    .acq_dat_o     (acq_dat_o),
    .acq_vld_o     (acq_vld_o),
    .acq_done_o    (acq_done_o),
    .acq_busy_o    (acq_busy_o),
    .trg_out_o     (trg_out_o),
    .acq_ts_o      (acq_ts_o)
  );

  initial begin
    adc_clk = 1'b0;
    forever #10 adc_clk = ~adc_clk;
  end

  // bench cycle count, for trigger spacing
  always @(posedge adc_clk) cyc <= cyc + 1;

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // gain, shift, offset, then clip
  function automatic int cal_ref(input int x, input int mul, input int sum);
    int p;
    p = ((x * mul) >>> CAL_SHIFT) + sum;
    if (p > int'(SMP_MAX)) p = int'(SMP_MAX);
    else if (p < int'(SMP_MIN)) p = int'(SMP_MIN);
    return p;
  endfunction

  // negative slope: word 0 is full scale positive
  function automatic row_t make_row(input int adc, input int gen, input int amul,
                                    input int asum, input int dmul, input int dsum,
                                    input logic loop, input int len);
    row_t r;
    int   dac_cal;
    r.adc_dat  = adc_raw_t'(adc);
    r.dac_gen  = smp_t'(gen);
    r.adc_mul  = cal_mul_t'(amul);
    r.adc_sum  = cal_sum_t'(asum);
    r.dac_mul  = cal_mul_t'(dmul);
    r.dac_sum  = cal_sum_t'(dsum);
    r.loop_en  = loop;
    r.post_len = len_t'(len);
    dac_cal    = cal_ref(int'(r.dac_gen), int'(r.dac_mul), int'(r.dac_sum));
    r.exp_dac  = 8191 - dac_cal;
    if (loop) r.exp_acq = cal_ref(dac_cal, int'(r.adc_mul), int'(r.adc_sum));
    else r.exp_acq = cal_ref(8191 - int'(r.adc_dat), int'(r.adc_mul), int'(r.adc_sum));
    return r;
  endfunction

  //////////////////////////////////////////////////
  // checks and drivers
  //////////////////////////////////////////////////

  task automatic check(input string name, input int got, input int exp);
    if (got != exp) begin
      errors++;
      $display("[FAIL] t=%0t %s got %0d expected %0d", $time, name, got, exp);
      $display("Done: errors found");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic apply_row(input row_t r);
    @(posedge adc_clk);
    adc_dat_i     <= r.adc_dat;
    dac_gen_i     <= r.dac_gen;
    adc_cal_mul_i <= r.adc_mul;
    adc_cal_sum_i <= r.adc_sum;
    dac_cal_mul_i <= r.dac_mul;
    dac_cal_sum_i <= r.dac_sum;
    loop_en_i     <= r.loop_en;
    post_len_i    <= r.post_len;
    // dac word two cycles on
    repeat (2) @(posedge adc_clk);
    @(negedge adc_clk);
    check("dac_dat_o", int'(dac_dat_o), r.exp_dac);
  endtask

  // arm, one sw trigger, then follow the whole frame
  task automatic sw_capture(input row_t r, output int trg_cyc);
    int n;
    int guard;
    @(posedge adc_clk);
    arm_i <= 1'b1;
    @(posedge adc_clk);
    arm_i    <= 1'b0;
    sw_trg_i <= 1'b1;
    @(posedge adc_clk);
    sw_trg_i <= 1'b0;
    guard = 0;
    @(negedge adc_clk);
    while (!acq_vld_o) begin
      guard++;
      if (guard > 20) begin
        $display("no valid sample appeared after the software trigger");
        $display("Done: errors found");
        $fatal(1, "capture did not start");
      end
      @(negedge adc_clk);
    end
    trg_cyc = cyc;
    check("trg_out_o", int'(trg_out_o), 1);
    n = 0;
    while (acq_vld_o) begin
      n++;
      check("acq_dat_o", int'(acq_dat_o), r.exp_acq);
      check("acq_done_o", int'(acq_done_o), int'(n == int'(r.post_len)));
      check("acq_busy_o", int'(acq_busy_o), 1);
      if (n > 1) check("trg_out_o", int'(trg_out_o), 0);
      @(negedge adc_clk);
    end
    check("valid count", n, int'(r.post_len));
    // busy drops right after the last sample
    check("acq_busy_o", int'(acq_busy_o), 0);
  endtask

  // trigger while idle must be ignored
  task automatic idle_trigger_check();
    int i;
    @(posedge adc_clk);
    sw_trg_i <= 1'b1;
    @(posedge adc_clk);
    sw_trg_i <= 1'b0;
    for (i = 0; i < 12; i++) begin
      @(negedge adc_clk);
      check("trg_out_o", int'(trg_out_o), 0);
      check("acq_vld_o", int'(acq_vld_o), 0);
    end
  endtask

  task automatic ext_capture(input row_t r);
    int          i;
    int          trg_n;
    int          vld_n;
    logic [5:0]  bounce;
    bounce = 6'b101101;
    trg_n  = 0;
    vld_n  = 0;
    apply_row(r);
    // arm stays high, a bounce that slipped through would start a second frame
    @(posedge adc_clk);
    arm_i <= 1'b1;
    // rise with bounces, all inside the hold-off
    for (i = 0; i < int'(r.post_len) + 30; i++) begin
      @(posedge adc_clk);
      if (i < 6) ext_trg_i <= bounce[i];
      @(negedge adc_clk);
      if (trg_out_o) trg_n++;
      if (acq_vld_o) begin
        vld_n++;
        check("acq_dat_o", int'(acq_dat_o), r.exp_acq);
      end
    end
    check("ext trg_out_o pulses", trg_n, 1);
    check("ext valid count", vld_n, int'(r.post_len));
    @(posedge adc_clk);
    arm_i     <= 1'b0;
    ext_trg_i <= 1'b0;
    repeat (DEB_CYCLES + 6) @(posedge adc_clk);
  endtask

  //////////////////////////////////////////////////
  // watchdog
  //////////////////////////////////////////////////

  initial begin
    int limit;
    wait (rows_ready);
    limit = 2000;
    foreach (rows[k]) limit += int'(rows[k].post_len) + 40;
    repeat (limit) @(posedge adc_clk);
    $display("timeout after %0d cycles, the run did not finish", limit);
    $display("Done: errors found");
    $fatal(1, "watchdog expired");
  end

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    int   k;
    int   trg_cyc;
    int   cyc_prev;
    ts_t  ts_prev;
    top_rst       = 1'b1;
    adc_dat_i     = '0;
    dac_gen_i     = '0;
    loop_en_i     = 1'b0;
    adc_cal_mul_i = '0;
    dac_cal_mul_i = '0;
    adc_cal_sum_i = '0;
    dac_cal_sum_i = '0;
    ext_trg_i     = 1'b0;
    sw_trg_i      = 1'b0;
    arm_i         = 1'b0;
    post_len_i    = '0;
    cyc_prev      = 0;
    ts_prev       = '0;
    // unity, full scale both ways, clipping, negative gain, rounding down
    rows.push_back(make_row(14'h0000, 0, 8192, 0, 8192, 0, 1'b0, 4));
    rows.push_back(make_row(14'h3fff, 0, 8192, 0, 8192, 0, 1'b0, 3));
    rows.push_back(make_row(14'h1000, 0, 16384, 100, 8192, 0, 1'b0, 5));
    rows.push_back(make_row(14'h3000, 0, 16384, -50, 8192, 0, 1'b0, 2));
    rows.push_back(make_row(14'h0800, 500, -8192, 10, 8192, 0, 1'b0, 1));
    rows.push_back(make_row(14'h2000, -300, 4096, 0, 8192, 0, 1'b0, 6));
    // loopback, adc pins carry junk
    rows.push_back(make_row(14'h1234, 1000, 8192, 5, 12288, -20, 1'b1, 4));
    rows.push_back(make_row(14'h2a5a, -7000, 4096, 0, 16384, 0, 1'b1, 3));
    for (k = 0; k < 6; k++) begin
      seed = xorshift(seed);
      rows.push_back(make_row(int'(seed[13:0]), int'(seed[27:14]),
                              int'($signed(seed[31:16])), int'($signed(seed[13:0])),
                              int'($signed(seed[23:8])), int'($signed(seed[17:4])),
                              seed[30], 1 + int'(seed[2:0])));
    end
    rows_ready = 1'b1;
    repeat (16) @(posedge adc_clk);
    top_rst <= 1'b0;
    @(negedge adc_clk);
    check("acq_vld_o", int'(acq_vld_o), 0);
    check("acq_busy_o", int'(acq_busy_o), 0);
    check("acq_done_o", int'(acq_done_o), 0);
    check("trg_out_o", int'(trg_out_o), 0);
    check("dac_dat_o", int'(dac_dat_o), 0);
    check("acq_dat_o", int'(acq_dat_o), 0);
    for (k = 0; k < rows.size(); k++) begin
      apply_row(rows[k]);
      sw_capture(rows[k], trg_cyc);
      // stamp spacing equals trigger spacing
      if (k > 0) check("acq_ts_o delta", int'(acq_ts_o - ts_prev), trg_cyc - cyc_prev);
      ts_prev  = acq_ts_o;
      cyc_prev = trg_cyc;
    end
    idle_trigger_check();
    // one-sample row, so the FSM is armed again while the pin still bounces
    ext_capture(rows[4]);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
src/rp_pkg.sv
src/acq_tmr_if.sv
src/linear_cal.sv
src/adc_frontend.sv
src/dac_backend.sv
src/edge_debounce.sv
src/acq_timer.sv
src/acq_fsm.sv
src/rp_analog_top.sv
bench/tb_rp_analog.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line in the log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rp_analog -f filelist.f \
  --Mdir obj_dir -o sim_tb > build.log 2>&1 ||
  { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -qx "Done: no errors" sim.log &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }
